//--- cache_two_way.f
rtl/cache_pkg.sv
rtl/block_mem_if.sv
rtl/cache_tag_lookup.sv
rtl/cache_data_array.sv
rtl/cache_controller.sv
rtl/block_memory.sv
rtl/cache_top.sv
verification/cache_checker.sv
verification/cache_tb.sv

//--- verification/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

  localparam int timeout_cycles = 40;
  localparam int num_random = 400;
  // 1 KiB window, word aligned
  localparam logic [31:0] addr_mask = 32'h0000_03fc;
  localparam int model_words = 256;

  logic clk;
  logic reset;
  logic is_input_valid;
  logic mem_read;
  logic mem_write;
  logic [cache_pkg::addr_width-1:0] addr;
  logic [cache_pkg::word_width-1:0] din;
  logic is_ready;
  logic is_output_valid;
  logic [cache_pkg::word_width-1:0] dout;
  logic is_hit;

  // reference model, word memory plus tags and fill order per set
  cache_pkg::word_t model_mem [model_words];
  cache_pkg::tag_t model_tag [cache_pkg::num_sets][cache_pkg::num_ways];
  logic model_valid [cache_pkg::num_sets][cache_pkg::num_ways];
  cache_pkg::way_t model_oldest [cache_pkg::num_sets];

  integer seed;
  int errors;
  int checks;
  int tests;
  int test_errors;
  bit timed_out;
  cache_pkg::word_t last_dout;
  logic last_hit;
  int last_latency;

  cache_top dut_i (
    .clk             (clk),
    .reset           (reset),
    .is_input_valid  (is_input_valid),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .addr            (addr),
    .din             (din),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .dout            (dout),
    .is_hit          (is_hit)
  );

  bind cache_controller cache_checker checker_i (
    .clk             (clk),
    .reset           (reset),
    .state           (state),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .req_valid       (mem.req_valid),
    .mem_ready       (mem.mem_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hit if either way of the set holds the tag
  function automatic logic model_hit(input logic [31:0] a);
    cache_pkg::index_t s;
    logic found;
    s = a[cache_pkg::offset_bits +: cache_pkg::index_bits];
    found = 1'b0;
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      if (model_valid[s][w] && model_tag[s][w] == a[31 -: cache_pkg::tag_bits]) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // empty way first, else oldest fill; refill makes the other way oldest
  function automatic void model_fill(input logic [31:0] a);
    cache_pkg::index_t s;
    cache_pkg::way_t w;
    s = a[cache_pkg::offset_bits +: cache_pkg::index_bits];
    if (!model_valid[s][0]) begin
      w = 1'b0;
    end else if (!model_valid[s][1]) begin
      w = 1'b1;
    end else begin
      w = model_oldest[s];
    end
    model_tag[s][w] = a[31 -: cache_pkg::tag_bits];
    model_valid[s][w] = 1'b1;
    model_oldest[s] = ~w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (timed_out) begin
      return;
    end
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
      errors++;
      test_errors++;
    end
  endtask

  task automatic drive_idle();
    is_input_valid = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    addr = '0;
    din = '0;
  endtask

  // one host request, checked against the model; called on a falling edge
  task automatic access(input bit is_write, input logic [31:0] a, input cache_pkg::word_t data);
    logic exp_hit;
    cache_pkg::word_t exp_dout;
    int cycles;
    bit seen;
    if (timed_out) begin
      return;
    end
    exp_hit = model_hit(a);
    exp_dout = model_mem[a[9:2]];
    cycles = 0;
    while (!is_ready && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!is_ready) begin
      $display("cache never raised is_ready within %0d cycles", timeout_cycles);
      errors++;
      test_errors++;
      timed_out = 1'b1;
      return;
    end
    is_input_valid = 1'b1;
    mem_read = !is_write;
    mem_write = is_write;
    addr = a;
    din = data;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      seen = is_output_valid;
    end
    if (!seen) begin
      $display("no response from the cache within %0d cycles for address %h",
               timeout_cycles, a);
      errors++;
      test_errors++;
      timed_out = 1'b1;
      drive_idle();
      return;
    end
    last_dout = dout;
    last_hit = is_hit;
    // edges from the accepting edge to the one raising is_output_valid
    last_latency = cycles - 1;
    drive_idle();
    if (!is_write) begin
      check_value("dout", last_dout, exp_dout);
    end
    check_value("is_hit", last_hit, exp_hit);
    if (!exp_hit) begin
      model_fill(a);
    end
    if (is_write) begin
      model_mem[a[9:2]] = data;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %-16s %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    bit wr;
    logic [31:0] a;
    seed = 45;
    errors = 0;
    checks = 0;
    tests = 0;
    test_errors = 0;
    timed_out = 1'b0;
    for (int i = 0; i < model_words; i++) begin
      model_mem[i] = '0;
    end
    for (int s = 0; s < cache_pkg::num_sets; s++) begin
      model_oldest[s] = 1'b0;
      for (int w = 0; w < cache_pkg::num_ways; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w] = '0;
      end
    end
    reset = 1'b1;
    drive_idle();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_value("is_ready", is_ready, 1'b1);
    check_value("is_output_valid", is_output_valid, 1'b0);
    report_test("reset_state");

    // fresh line in set 2, then the same word again
    access(1'b0, 32'h0000_0024, '0);
    check_value("dout", last_dout, 32'h0);
    check_value("is_hit", last_hit, 1'b0);
    access(1'b0, 32'h0000_0024, '0);
    check_value("is_hit", last_hit, 1'b1);
    check_value("hit latency", last_latency, 2);
    report_test("read_miss_hit");

    access(1'b1, 32'h0000_0034, 32'hcafe_0001);
    access(1'b0, 32'h0000_0034, '0);
    check_value("dout", last_dout, 32'hcafe_0001);
    check_value("is_hit", last_hit, 1'b1);
    // neighbour word of the same line
    access(1'b0, 32'h0000_0038, '0);
    check_value("is_hit", last_hit, 1'b1);
    report_test("write_read");

    // three tags in set 5, third write evicts the dirty first line
    access(1'b1, 32'h0000_0050, 32'h1111_aaaa);
    access(1'b1, 32'h0000_00d0, 32'h2222_bbbb);
    access(1'b1, 32'h0000_0150, 32'h3333_cccc);
    access(1'b0, 32'h0000_0050, '0);
    check_value("is_hit", last_hit, 1'b0);
    check_value("dout", last_dout, 32'h1111_aaaa);
    report_test("dirty_eviction");

    for (int i = 0; i < num_random; i++) begin
      a = $random(seed) & addr_mask;
      wr = $random(seed) & 1;
      access(wr, a, $random(seed));
    end
    report_test("random_mix");

    errors += dut_i.ctrl_i.checker_i.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verification/cache_checker.sv
`timescale 1ns/1ns

module cache_checker (
  input logic                    clk,
  input logic                    reset,
  input cache_pkg::cache_state_t state,
  input logic                    is_ready,
  input logic                    is_output_valid,
  input logic                    req_valid,
  input logic                    mem_ready
);

  // failed properties so far
  int fail_count = 0;

  // response strobe is a single-cycle pulse
  output_pulse_a: assert property (@(posedge clk) disable iff (reset)
    is_output_valid |=> !is_output_valid)
    else begin
      $error("is_output_valid stayed high for two cycles");
      fail_count++;
    end

  // memory takes a request only while idle
  req_ready_a: assert property (@(posedge clk) disable iff (reset)
    req_valid |-> mem_ready)
    else begin
      $error("req_valid raised while mem_ready was low");
      fail_count++;
    end

  // no state outside the FSM encoding
  state_legal_a: assert property (@(posedge clk) disable iff (reset)
    state inside {cache_pkg::st_idle, cache_pkg::st_compare, cache_pkg::st_write_back,
                  cache_pkg::st_allocate, cache_pkg::st_respond})
    else begin
      $error("controller state left the legal encoding");
      fail_count++;
    end

  // host is held off while a request is busy
  ready_idle_a: assert property (@(posedge clk) disable iff (reset)
    (state != cache_pkg::st_idle) |-> !is_ready)
    else begin
      $error("is_ready high outside st_idle");
      fail_count++;
    end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/1ns

module cache_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             is_input_valid,
  input  logic                             mem_read,
  input  logic                             mem_write,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  logic [cache_pkg::word_width-1:0] din,
  output logic                             is_ready,
  output logic                             is_output_valid,
  output logic [cache_pkg::word_width-1:0] dout,
  output logic                             is_hit
);

  // lookup results
  logic hit;
  cache_pkg::way_t hit_way;
  cache_pkg::way_t victim_way;
  logic victim_dirty;
  cache_pkg::tag_t victim_tag;
  cache_pkg::line_t victim_line;

  // controller strobes
  logic fill;
  logic set_dirty;
  logic write_word;
  cache_pkg::way_t sel_way;

  block_mem_if mem_bus ();

  // decode
  cache_tag_lookup lookup_i (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .fill         (fill),
    .fill_way     (sel_way),
    .set_dirty    (set_dirty),
    .dirty_way    (sel_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // execute
  cache_controller ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .is_input_valid  (is_input_valid),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .addr            (addr),
    .hit             (hit),
    .hit_way         (hit_way),
    .victim_way      (victim_way),
    .victim_dirty    (victim_dirty),
    .victim_tag      (victim_tag),
    .victim_line     (victim_line),
    .mem             (mem_bus.controller),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .is_hit          (is_hit),
    .fill            (fill),
    .set_dirty       (set_dirty),
    .write_word      (write_word),
    .sel_way         (sel_way)
  );

  // result, refill straight from memory read data
  cache_data_array data_i (
    .clk         (clk),
    .addr        (addr),
    .din         (din),
    .fill        (fill),
    .write_word  (write_word),
    .sel_way     (sel_way),
    .fill_line   (mem_bus.rdata),
    .dout        (dout),
    .victim_line (victim_line)
  );

  block_memory mem_i (
    .clk   (clk),
    .reset (reset),
    .mem   (mem_bus.memory)
  );

endmodule

//--- rtl/block_memory.sv
`timescale 1ns/1ns

module block_memory (
  input  logic        clk,
  input  logic        reset,
  block_mem_if.memory mem
);

  // zero at start, no reset on the array
  cache_pkg::line_t mem_array [cache_pkg::mem_lines] = '{default: '0};

  cache_pkg::lat_cnt_t lat_cnt;
  logic [cache_pkg::mem_index_bits-1:0] line_index;
  logic accept;

  // upper line number bits are ignored
  assign line_index = mem.req_line[cache_pkg::mem_index_bits-1:0];
  assign accept = mem.req_valid && mem.mem_ready;

  // last busy cycle
  assign mem.rsp_valid = !mem.mem_ready && (lat_cnt == '0);

  // busy window of mem_latency cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      mem.mem_ready <= 1'b1;
      lat_cnt <= '0;
    end else if (accept) begin
      mem.mem_ready <= 1'b0;
      lat_cnt <= cache_pkg::lat_cnt_t'(cache_pkg::mem_latency - 1);
    end else if (!mem.mem_ready) begin
      if (lat_cnt == '0) begin
        mem.mem_ready <= 1'b1;
      end else begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

  // array access at request time
  // read data then holds until the response
  always_ff @(posedge clk) begin
    if (accept) begin
      if (mem.req_write) begin
        mem_array[line_index] <= mem.wdata;
      end else begin
        mem.rdata <= mem_array[line_index];
      end
    end
  end

endmodule

//--- rtl/cache_controller.sv
`timescale 1ns/1ns

module cache_controller (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             is_input_valid,
  input  logic                             mem_read,
  input  logic                             mem_write,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  logic                             hit,
  input  cache_pkg::way_t                  hit_way,
  input  cache_pkg::way_t                  victim_way,
  input  logic                             victim_dirty,
  input  cache_pkg::tag_t                  victim_tag,
  input  cache_pkg::line_t                 victim_line,
  block_mem_if.controller                  mem,
  output logic                             is_ready,
  output logic                             is_output_valid,
  output logic                             is_hit,
  output logic                             fill,
  output logic                             set_dirty,
  output logic                             write_word,
  output cache_pkg::way_t                  sel_way
);

  cache_pkg::cache_state_t state;
  // high during the first compare of a request
  logic first_lookup;
  logic first_miss;
  cache_pkg::way_t way_q;
  cache_pkg::way_t way_choice;
  cache_pkg::index_t set_index;

  assign set_index = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign way_choice = hit ? hit_way : victim_way;

  // first compare steers by the lookup, later states by the latched way
  assign sel_way = (state == cache_pkg::st_compare && first_lookup) ? way_choice : way_q;

  assign is_ready = (state == cache_pkg::st_idle);
  assign fill = (state == cache_pkg::st_allocate) && mem.rsp_valid;
  // write hit lands in the respond cycle, addr and din still held
  assign write_word = (state == cache_pkg::st_respond) && mem_write;
  assign set_dirty = write_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::st_idle;
      first_lookup <= 1'b0;
      first_miss <= 1'b0;
      way_q <= '0;
      mem.req_valid <= 1'b0;
      is_output_valid <= 1'b0;
      is_hit <= 1'b0;
    end else begin
      // pulses by default
      mem.req_valid <= 1'b0;
      is_output_valid <= 1'b0;
      is_hit <= 1'b0;
      case (state)
        cache_pkg::st_idle: begin
          if (is_input_valid && (mem_read || mem_write)) begin
            first_lookup <= 1'b1;
            state <= cache_pkg::st_compare;
          end
        end
        cache_pkg::st_compare: begin
          first_lookup <= 1'b0;
          if (first_lookup) begin
            first_miss <= !hit;
            way_q <= way_choice;
          end
          if (hit) begin
            state <= cache_pkg::st_respond;
          end else if (victim_dirty) begin
            // evict first, refill after
            mem.req_valid <= 1'b1;
            state <= cache_pkg::st_write_back;
          end else begin
            mem.req_valid <= 1'b1;
            state <= cache_pkg::st_allocate;
          end
        end
        cache_pkg::st_write_back: begin
          // memory is ready again the cycle after its response
          if (mem.rsp_valid) begin
            mem.req_valid <= 1'b1;
            state <= cache_pkg::st_allocate;
          end
        end
        cache_pkg::st_allocate: begin
          // refill lands this edge, recompare hits
          if (mem.rsp_valid) begin
            state <= cache_pkg::st_compare;
          end
        end
        cache_pkg::st_respond: begin
          is_output_valid <= 1'b1;
          is_hit <= !first_miss;
          state <= cache_pkg::st_idle;
        end
        default: begin
          state <= cache_pkg::st_idle;
        end
      endcase
    end
  end

  // request payload, sampled by memory together with req_valid
  always_ff @(posedge clk) begin
    if (state == cache_pkg::st_compare && victim_dirty) begin
      // victim line number from its own tag and this set
      mem.req_write <= 1'b1;
      mem.req_line <= {victim_tag, set_index};
      mem.wdata <= victim_line;
    end else begin
      mem.req_write <= 1'b0;
      mem.req_line <= addr[cache_pkg::addr_width-1:cache_pkg::offset_bits];
    end
  end

endmodule

//--- rtl/cache_data_array.sv
`timescale 1ns/1ns

module cache_data_array (
  input  logic                             clk,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  cache_pkg::word_t                 din,
  input  logic                             fill,
  input  logic                             write_word,
  input  cache_pkg::way_t                  sel_way,
  input  cache_pkg::line_t                 fill_line,
  output cache_pkg::word_t                 dout,
  output cache_pkg::line_t                 victim_line
);

  // line storage, both ways of every set
  cache_pkg::line_t lines_q [cache_pkg::num_sets][cache_pkg::num_ways];

  cache_pkg::index_t set_index;
  logic [cache_pkg::word_sel_bits-1:0] word_sel;

  assign set_index = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign word_sel = addr[cache_pkg::byte_bits +: cache_pkg::word_sel_bits];

  // selected line, also the write-back payload
  assign victim_line = lines_q[set_index][sel_way];

  // word mux for reads
  assign dout = victim_line[word_sel * cache_pkg::word_width +: cache_pkg::word_width];

  always_ff @(posedge clk) begin
    if (fill) begin
      // whole line from memory
      lines_q[set_index][sel_way] <= fill_line;
    end else if (write_word) begin
      // merge one host word into the line
      lines_q[set_index][sel_way][word_sel * cache_pkg::word_width +: cache_pkg::word_width]
        <= din;
    end
  end

endmodule

//--- rtl/cache_tag_lookup.sv
`timescale 1ns/1ns

module cache_tag_lookup (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  logic                             fill,
  input  cache_pkg::way_t                  fill_way,
  input  logic                             set_dirty,
  input  cache_pkg::way_t                  dirty_way,
  output logic                             hit,
  output cache_pkg::way_t                  hit_way,
  output cache_pkg::way_t                  victim_way,
  output logic                             victim_dirty,
  output cache_pkg::tag_t                  victim_tag
);

  cache_pkg::tag_t tag_q [cache_pkg::num_sets][cache_pkg::num_ways];
  logic [cache_pkg::num_ways-1:0] valid_q [cache_pkg::num_sets];
  logic [cache_pkg::num_ways-1:0] dirty_q [cache_pkg::num_sets];
  // per set, way filled longest ago
  logic [cache_pkg::num_sets-1:0] repl_q;

  cache_pkg::index_t set_index;
  cache_pkg::tag_t addr_tag;
  logic [cache_pkg::num_ways-1:0] match;

  assign set_index = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign addr_tag = addr[cache_pkg::addr_width-1 -: cache_pkg::tag_bits];

  // tag compare on both ways of the addressed set
  always_comb begin
    for (int w = 0; w < cache_pkg::num_ways; w++) begin
      match[w] = valid_q[set_index][w] && (tag_q[set_index][w] == addr_tag);
    end
  end

  assign hit = |match;
  // way 0 wins if both match
  assign hit_way = !match[0];

  // empty way first, else the oldest fill
  always_comb begin
    if (!valid_q[set_index][0]) begin
      victim_way = 1'b0;
    end else if (!valid_q[set_index][1]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = repl_q[set_index];
    end
  end

  assign victim_dirty = valid_q[set_index][victim_way] && dirty_q[set_index][victim_way];
  assign victim_tag = tag_q[set_index][victim_way];

  // valid, dirty and replacement state
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < cache_pkg::num_sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      repl_q <= '0;
    end else begin
      if (fill) begin
        valid_q[set_index][fill_way] <= 1'b1;
        dirty_q[set_index][fill_way] <= 1'b0;
        // other way is now the older one
        repl_q[set_index] <= ~fill_way;
      end
      if (set_dirty) begin
        dirty_q[set_index][dirty_way] <= 1'b1;
      end
    end
  end

  // tags only change on refill
  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[set_index][fill_way] <= addr_tag;
    end
  end

endmodule

//--- rtl/block_mem_if.sv
`timescale 1ns/1ns

interface block_mem_if;

  // request side, from the cache controller
  logic req_valid;
  logic req_write;
  logic [cache_pkg::line_num_bits-1:0] req_line;
  cache_pkg::line_t wdata;

  // response side, from the backing memory
  logic mem_ready;
  logic rsp_valid;
  cache_pkg::line_t rdata;

  modport controller (
    output req_valid,
    output req_write,
    output req_line,
    output wdata,
    input  mem_ready,
    input  rsp_valid,
    input  rdata
  );

  modport memory (
    input  req_valid,
    input  req_write,
    input  req_line,
    input  wdata,
    output mem_ready,
    output rsp_valid,
    output rdata
  );

endinterface

//--- rtl/cache_pkg.sv
package cache_pkg;

  // address and data geometry
  localparam int addr_width = 32;
  localparam int word_width = 32;
  localparam int words_per_line = 4;
  localparam int line_width = word_width * words_per_line;

  // address split: tag 31:7, set 6:4, word 3:2, byte 1:0
  localparam int offset_bits = 4;
  localparam int index_bits = 3;
  localparam int num_sets = 1 << index_bits;
  localparam int num_ways = 2;
  localparam int tag_bits = addr_width - index_bits - offset_bits;
  localparam int byte_bits = 2;
  localparam int word_sel_bits = $clog2(words_per_line);

  // line number as seen by the backing memory
  localparam int line_num_bits = addr_width - offset_bits;

  // backing memory
  localparam int mem_lines = 256;
  localparam int mem_index_bits = $clog2(mem_lines);
  localparam int mem_latency = 4;
  localparam int lat_cnt_bits = $clog2(mem_latency);

  typedef logic [line_width-1:0] line_t;
  typedef logic [word_width-1:0] word_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [$clog2(num_ways)-1:0] way_t;
  typedef logic [lat_cnt_bits-1:0] lat_cnt_t;

  // miss handling FSM
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_compare    = 3'd1,
    st_write_back = 3'd2,
    st_allocate   = 3'd3,
    st_respond    = 3'd4
  } cache_state_t;

endpackage
